/* bench/laser310_trace.txt */
# op addr data expect (hex) W/R memory, P I/O write, L latency with turbo, H held read
# O outputs {spk,cass,ag,css,gm}, K key code pressed, C cass in, T turbo, S reset with switch
O 0000 00 02
W 7000 11 00
W 77FF 22 00
W 7800 33 00
W 8000 44 00
W B7FF 55 00
W 7000 66 00
R 7000 00 66
R 77FF 00 22
R 7800 00 33
R 8000 00 44
R B7FF 00 55
R 0000 00 FF
R C000 00 FF
L 8000 01 04
L 8000 00 0E
T 0000 01 00
H B7FF 05 55
W 6800 21 00
O 0000 00 C2
W 6800 1C 00
O 0000 00 3A
W 6800 0D 00
O 0000 00 B2
P 0020 14 00
O 0000 00 B5
S 0000 00 00
O 0000 00 02
P 0020 14 00
O 0000 00 02
C 0000 01 00
R 68FF 00 BF
C 0000 00 00
K 0015 01 00
K 001C 01 00
K 005A 01 00
R 68FE 00 EF
R 68FD 00 EF
R 68BF 00 FB
R 68BE 00 EB
R 68FB 00 FF
K 0015 00 00
R 68FE 00 FF
R 68FC 00 EF

/* build.f */
+incdir+source
source/laser_bus_pkg.sv
source/laser_kbd_pkg.sv
source/laser_bus_if.sv
source/bus_decode.sv
source/mem_execute.sv
source/read_result.sv
source/laser310_core.sv
bench/tb_clock.sv
bench/laser310_assert.sv
bench/tb_laser310.sv

/* Makefile */
SIM := obj_dir/Vtb_laser310

.PHONY: all run clean

all: run

$(SIM): build.f $(wildcard source/*.sv source/*.svh bench/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_laser310 -f build.f

run: $(SIM) bench/laser310_trace.txt
	$(SIM) +verilator+error+limit+100 | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/tb_laser310.sv */
`timescale 1ns/1ps

module tb_laser310
	import laser_bus_pkg::*;
	import laser_kbd_pkg::*;
();

	logic       CLK50MHZ;
	logic       RESET_N;
	logic       reset_req;
	logic       bus_req;
	addr_t      bus_addr;
	data_t      bus_wdata;
	logic       bus_we;
	logic       bus_iorq;
	logic       turbo;
	logic       shrg_en;
	logic       key_strobe;
	logic       key_pressed;
	ps2_code_t  key_code;
	logic       cass_in;
	logic       bus_ack;
	data_t      bus_rdata;
	logic [1:0] spk;
	logic       cass_out;
	logic       vdg_ag;
	logic       vdg_css;
	logic [2:0] vdg_gm;

	// One entry per trace line
	logic [7:0] op_q [$];
	addr_t      addr_q [$];
	data_t      data_q [$];
	data_t      exp_q [$];

	int   n_tests = 0;
	int   n_err = 0;
	int   cycles = 0;
	int   cycle_limit = 0;
	int   assert_fails;
	logic test_ok;

	tb_clock i_tb_clock
	(
		.CLK50MHZ    (CLK50MHZ),
		.RESET_N     (RESET_N),
		.reset_req_i (reset_req)
	);

	laser310_core i_laser310_core
	(
		.CLK50MHZ      (CLK50MHZ),
		.RESET_N       (RESET_N),
		.bus_req_i     (bus_req),
		.bus_addr_i    (bus_addr),
		.bus_wdata_i   (bus_wdata),
		.bus_we_i      (bus_we),
		.bus_iorq_i    (bus_iorq),
		.turbo_i       (turbo),
		.shrg_en_i     (shrg_en),
		.key_strobe_i  (key_strobe),
		.key_pressed_i (key_pressed),
		.key_code_i    (key_code),
		.cass_in_i     (cass_in),
		.bus_ack_o     (bus_ack),
		.bus_rdata_o   (bus_rdata),
		.spk_o         (spk),
		.cass_out_o    (cass_out),
		.vdg_ag_o      (vdg_ag),
		.vdg_css_o     (vdg_css),
		.vdg_gm_o      (vdg_gm)
	);

	// Inputs change 2 ns after the rising edge
	task automatic drive_slot();
		@(posedge CLK50MHZ);
		#2;
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			n_err++;
			test_ok = 1'b0;
		end
	endtask

	task automatic check_latency(input string name, input int got, input int exp);
		if (got != exp)
		begin
			$display("mismatch %s: got %0h expected %0h", name, got, exp);
			n_err++;
			test_ok = 1'b0;
		end
	endtask

	task automatic check_outputs(input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
		begin
			$display("mismatch {spk_o,cass_out_o,vdg_ag_o,vdg_css_o,vdg_gm_o}: got %h expected %h",
				got, exp);
			n_err++;
			test_ok = 1'b0;
		end
	endtask

	// One four-phase transfer
	task automatic bus_transfer(input addr_t a, input data_t d, input logic we, input logic iorq,
		input int hold, input data_t hold_exp, output data_t rd, output int lat);
		int n;
		n = 0;
		drive_slot();
		bus_addr  = a;
		bus_wdata = d;
		bus_we    = we;
		bus_iorq  = iorq;
		bus_req   = 1'b1;
		do
		begin
			@(posedge CLK50MHZ);
			#1;
			n++;
		end
		while (!bus_ack);
		rd  = bus_rdata;
		lat = n - 1;   // Edges from the req sample to ack
		for (int i = 0; i < hold; i++)
		begin
			@(posedge CLK50MHZ);
			#1;
			if (!bus_ack)
			begin
				$display("ack dropped while the request was still held");
				n_err++;
				test_ok = 1'b0;
			end
			check_data("bus_rdata_o", bus_rdata, hold_exp);
		end
		#1;
		bus_req = 1'b0;
		do
		begin
			@(posedge CLK50MHZ);
			#1;
		end
		while (bus_ack);
	endtask

	task automatic key_event(input ps2_code_t code, input logic pressed);
		drive_slot();
		key_code    = code;
		key_pressed = pressed;
		key_strobe  = 1'b1;
		drive_slot();
		key_strobe  = 1'b0;
	endtask

	// Switch is sampled by the core while reset is low
	task automatic apply_reset(input logic en);
		drive_slot();
		shrg_en   = en;
		reset_req = 1'b1;
		@(posedge RESET_N);
		reset_req = 1'b0;
	endtask

	task automatic load_trace();
		int         fd;
		int         cnt;
		string      line;
		logic [7:0] op;
		addr_t      a;
		data_t      d;
		data_t      e;
		fd = $fopen("bench/laser310_trace.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open the trace file bench/laser310_trace.txt");
			n_err++;
			return;
		end
		while ($fgets(line, fd) != 0)
		begin
			if (line.len() == 0 || line[0] == "#")
				continue;
			cnt = $sscanf(line, "%c %h %h %h", op, a, d, e);
			if (cnt == 4)
			begin
				op_q.push_back(op);
				addr_q.push_back(a);
				data_q.push_back(d);
				exp_q.push_back(e);
			end
		end
		$fclose(fd);
	endtask

	task automatic run_op(input int idx);
		logic [7:0] op;
		addr_t      a;
		data_t      d;
		data_t      e;
		data_t      rd;
		int         lat;
		logic       checked;
		op      = op_q[idx];
		a       = addr_q[idx];
		d       = data_q[idx];
		e       = exp_q[idx];
		test_ok = 1'b1;
		checked = 1'b1;
		case (op)
			"W":
			begin
				bus_transfer(a, d, 1'b1, 1'b0, 0, 8'h00, rd, lat);
				checked = 1'b0;
			end
			"P":
			begin
				bus_transfer(a, d, 1'b1, 1'b1, 0, 8'h00, rd, lat);   // I/O write
				checked = 1'b0;
			end
			"R":
			begin
				bus_transfer(a, 8'h00, 1'b0, 1'b0, 0, 8'h00, rd, lat);
				check_data("bus_rdata_o", rd, e);
			end
			"H":
			begin
				bus_transfer(a, 8'h00, 1'b0, 1'b0, int'(d), e, rd, lat);
				check_data("bus_rdata_o", rd, e);
			end
			"L":
			begin
				drive_slot();
				turbo = d[0];
				bus_transfer(a, 8'h00, 1'b0, 1'b0, 0, 8'h00, rd, lat);
				check_latency("bus_ack_o latency", lat, int'(e));
			end
			"O":
			begin
				drive_slot();
				check_outputs({spk, cass_out, vdg_ag, vdg_css, vdg_gm}, e);
			end
			"K":
			begin
				key_event(ps2_code_t'(a[7:0]), d[0]);
				checked = 1'b0;
			end
			"C":
			begin
				drive_slot();
				cass_in = d[0];
				checked = 1'b0;
			end
			"T":
			begin
				drive_slot();
				turbo   = d[0];
				checked = 1'b0;
			end
			"S":
			begin
				apply_reset(d[0]);
				checked = 1'b0;
			end
			default:
			begin
				$display("unknown trace operation %c in entry %0d", op, idx);
				n_err++;
				test_ok = 1'b0;
			end
		endcase
		if (checked)
		begin
			n_tests++;
			$display("test %0d %c %h: %s", n_tests, op, a, test_ok ? "ok" : "failed");
		end
	endtask

	// Watchdog limit scales with the trace length
	initial
	begin
		wait (cycle_limit > 0);
		while (cycles < cycle_limit)
		begin
			@(posedge CLK50MHZ);
			cycles++;
		end
		$display("timeout after %0d cycles, the DUT stopped answering", cycles);
		$display("FAIL: see errors above");
		$finish;
	end

	initial
	begin
		reset_req   = 1'b0;
		bus_req     = 1'b0;
		bus_addr    = '0;
		bus_wdata   = '0;
		bus_we      = 1'b0;
		bus_iorq    = 1'b0;
		turbo       = 1'b1;
		shrg_en     = 1'b1;
		key_strobe  = 1'b0;
		key_pressed = 1'b0;
		key_code    = '0;
		cass_in     = 1'b0;
		load_trace();
		cycle_limit = op_q.size() * 40;
		@(posedge RESET_N);
		for (int i = 0; i < op_q.size(); i++)
			run_op(i);
		assert_fails = i_laser310_core.i_laser310_assert.fail_cnt;
		if (assert_fails != 0)
		begin
			$display("%0d handshake assertions failed", assert_fails);
			n_err += assert_fails;
		end
		$display("%0d tests run, %0d errors", n_tests, n_err);
		if (n_err == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* bench/laser310_assert.sv */
`timescale 1ns/1ps

module laser310_assert
(
	input logic CLK50MHZ,
	input logic RESET_N,
	input logic bus_req_i,
	input logic bus_ack_i
);

	int fail_reset = 0;
	int fail_rise  = 0;
	int fail_fall  = 0;
	int fail_cnt;

	assign fail_cnt = fail_reset + fail_rise + fail_fall;

	ack_low_in_reset: assert property (@(posedge CLK50MHZ) !RESET_N |-> !bus_ack_i)
	else
	begin
		fail_reset++;
		$error("bus ack high while reset is asserted");
	end

	// Ack only answers a pending request
	ack_rise_on_req: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		$rose(bus_ack_i) |-> $past(bus_req_i))
	else
	begin
		fail_rise++;
		$error("bus ack rose without a request");
	end

	ack_hold_on_req: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		$fell(bus_ack_i) |-> !$past(bus_req_i))
	else
	begin
		fail_fall++;
		$error("bus ack fell while the request was still high");
	end

endmodule

bind laser310_core laser310_assert i_laser310_assert
(
	.CLK50MHZ  (CLK50MHZ),
	.RESET_N   (RESET_N),
	.bus_req_i (bus_req_i),
	.bus_ack_i (bus_ack_o)
);

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock
(
	output logic CLK50MHZ,
	output logic RESET_N,
	input  logic reset_req_i
);

	initial
	begin
		CLK50MHZ = 1'b0;
		forever
			#10 CLK50MHZ = ~CLK50MHZ;   // 50 MHz
	end

	// Three cycles of reset at start, and again on every request
	always
	begin
		RESET_N = 1'b0;
		repeat (3) @(posedge CLK50MHZ);
		#2;
		RESET_N = 1'b1;
		@(posedge reset_req_i);
	end

endmodule

/* source/laser310_core.sv */
`timescale 1ns/1ps

module laser310_core
	import laser_bus_pkg::*;
	import laser_kbd_pkg::*;
(
	input  logic       CLK50MHZ,
	input  logic       RESET_N,
	input  logic       bus_req_i,
	input  addr_t      bus_addr_i,
	input  data_t      bus_wdata_i,
	input  logic       bus_we_i,
	input  logic       bus_iorq_i,
	input  logic       turbo_i,
	input  logic       shrg_en_i,
	input  logic       key_strobe_i,
	input  logic       key_pressed_i,
	input  ps2_code_t  key_code_i,
	input  logic       cass_in_i,
	output logic       bus_ack_o,
	output data_t      bus_rdata_o,
	output logic [1:0] spk_o,
	output logic       cass_out_o,
	output logic       vdg_ag_o,
	output logic       vdg_css_o,
	output logic [2:0] vdg_gm_o
);

	data_t out_latch;
	data_t shrg_latch;

	laser_bus_if bus_if ();

	bus_decode i_bus_decode
	(
		.CLK50MHZ    (CLK50MHZ),
		.RESET_N     (RESET_N),
		.bus_req_i   (bus_req_i),
		.bus_addr_i  (bus_addr_i),
		.bus_wdata_i (bus_wdata_i),
		.bus_we_i    (bus_we_i),
		.bus_iorq_i  (bus_iorq_i),
		.turbo_i     (turbo_i),
		.bus_ack_o   (bus_ack_o),
		.bus_o       (bus_if.decode)
	);

	mem_execute i_mem_execute
	(
		.CLK50MHZ     (CLK50MHZ),
		.RESET_N      (RESET_N),
		.shrg_en_i    (shrg_en_i),
		.bus_i        (bus_if.execute),
		.out_latch_o  (out_latch),
		.shrg_latch_o (shrg_latch)
	);

	read_result i_read_result
	(
		.CLK50MHZ      (CLK50MHZ),
		.RESET_N       (RESET_N),
		.key_strobe_i  (key_strobe_i),
		.key_pressed_i (key_pressed_i),
		.key_code_i    (key_code_i),
		.cass_in_i     (cass_in_i),
		.bus_i         (bus_if.result),
		.bus_rdata_o   (bus_rdata_o)
	);

	assign spk_o      = {out_latch[0], out_latch[5]};  // Speaker pair
	assign cass_out_o = out_latch[2];
	assign vdg_ag_o   = out_latch[3];
	assign vdg_css_o  = out_latch[4];
	assign vdg_gm_o   = shrg_latch[4:2];

endmodule

/* source/read_result.sv */
`timescale 1ns/1ps

module read_result
	import laser_bus_pkg::*;
	import laser_kbd_pkg::*;
(
	input  logic        CLK50MHZ,
	input  logic        RESET_N,
	input  logic        key_strobe_i,
	input  logic        key_pressed_i,
	input  ps2_code_t   key_code_i,
	input  logic        cass_in_i,
	laser_bus_if.result bus_i,
	output data_t       bus_rdata_o
);

	key_matrix_t key_matrix;
	key_row_t    row_sel;
	logic [5:0]  key_data;
	logic        key_n;

	assign key_n   = ~key_pressed_i;
	assign row_sel = bus_i.addr[7:0];   // Low address bit selects a row

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
			key_matrix <= '1;
		else if (key_strobe_i)
		begin
			case (key_code_i)
				8'h16: key_matrix[28] <= key_n;   // 1
				8'h1E: key_matrix[25] <= key_n;   // 2
				8'h26: key_matrix[27] <= key_n;   // 3
				8'h25: key_matrix[29] <= key_n;   // 4
				8'h2E: key_matrix[24] <= key_n;   // 5
				8'h36: key_matrix[40] <= key_n;   // 6
				8'h3D: key_matrix[45] <= key_n;   // 7
				8'h3E: key_matrix[43] <= key_n;   // 8
				8'h46: key_matrix[41] <= key_n;   // 9
				8'h45: key_matrix[44] <= key_n;   // 0
				8'h4E: key_matrix[42] <= key_n;   // Minus
				8'h49: key_matrix[33] <= key_n;   // Period
				8'h41: key_matrix[35] <= key_n;   // Comma
				8'h4C: key_matrix[60] <= key_n;   // Semicolon
				8'h52: key_matrix[58] <= key_n;   // Quote maps to colon
				8'h5A: key_matrix[50] <= key_n;   // Enter
				8'h29: key_matrix[36] <= key_n;   // Space
				8'h14: key_matrix[10] <= key_n;   // Ctrl
				8'h12: key_matrix[18] <= key_n;   // Left shift
				8'h15: key_matrix[4]  <= key_n;   // Q
				8'h1D: key_matrix[1]  <= key_n;   // W
				8'h24: key_matrix[3]  <= key_n;   // E
				8'h2D: key_matrix[5]  <= key_n;   // R
				8'h2C: key_matrix[0]  <= key_n;   // T
				8'h35: key_matrix[48] <= key_n;   // Y
				8'h3C: key_matrix[53] <= key_n;   // U
				8'h43: key_matrix[51] <= key_n;   // I
				8'h44: key_matrix[49] <= key_n;   // O
				8'h4D: key_matrix[52] <= key_n;   // P
				8'h1C: key_matrix[12] <= key_n;   // A
				8'h1B: key_matrix[9]  <= key_n;   // S
				8'h23: key_matrix[11] <= key_n;   // D
				8'h2B: key_matrix[13] <= key_n;   // F
				8'h34: key_matrix[8]  <= key_n;   // G
				8'h33: key_matrix[56] <= key_n;   // H
				8'h3B: key_matrix[61] <= key_n;   // J
				8'h42: key_matrix[59] <= key_n;   // K
				8'h4B: key_matrix[57] <= key_n;   // L
				8'h1A: key_matrix[20] <= key_n;   // Z
				8'h22: key_matrix[17] <= key_n;   // X
				8'h21: key_matrix[19] <= key_n;   // C
				8'h2A: key_matrix[21] <= key_n;   // V
				8'h32: key_matrix[16] <= key_n;   // B
				8'h31: key_matrix[32] <= key_n;   // N
				8'h3A: key_matrix[37] <= key_n;   // M
				default: ;
			endcase
		end
	end

	// Every strobed row pulls its pressed columns low
	always_comb
	begin
		key_data = '1;
		for (int r = 0; r < 8; r++)
			if (!row_sel[r])
				key_data = key_data & key_matrix[r*8 +: 6];
	end

	always_comb
	begin
		case (bus_i.region)
			REG_IO:            bus_rdata_o = {1'b1, ~cass_in_i, key_data};
			REG_VRAM, REG_RAM: bus_rdata_o = bus_i.mem_rdata;
			default:           bus_rdata_o = 8'hFF;   // Nothing drives the bus
		endcase
	end

endmodule

/* source/mem_execute.sv */
`timescale 1ns/1ps
`include "laser_cfg.svh"

module mem_execute
	import laser_bus_pkg::*;
(
	input  logic         CLK50MHZ,
	input  logic         RESET_N,
	input  logic         shrg_en_i,
	laser_bus_if.execute bus_i,
	output data_t        out_latch_o,
	output data_t        shrg_latch_o
);

	localparam int VRAM_DEPTH = 2 ** $bits(vram_addr_t);
	localparam int RAM_DEPTH  = 2 ** $bits(ram_addr_t);

	data_t      vram [VRAM_DEPTH];
	data_t      ram  [RAM_DEPTH];
	data_t      vram_q;
	data_t      ram_q;
	vram_addr_t vram_idx;
	ram_addr_t  ram_idx;
	logic       wr_stb;
	logic       shrg_en;

	assign vram_idx = bus_i.addr[$bits(vram_addr_t)-1:0];
	assign ram_idx  = bus_i.addr[$bits(ram_addr_t)-1:0];  // 7800 folds to 3800
	assign wr_stb   = bus_i.exec_stb & bus_i.we;

	// Video RAM, CPU side only
	always_ff @(posedge CLK50MHZ)
	begin
		if (bus_i.exec_stb && bus_i.region == REG_VRAM)
		begin
			if (bus_i.we)
				vram[vram_idx] <= bus_i.wdata;
			vram_q <= vram[vram_idx];
		end
	end

	always_ff @(posedge CLK50MHZ)
	begin
		if (bus_i.exec_stb && bus_i.region == REG_RAM)
		begin
			if (bus_i.we)
				ram[ram_idx] <= bus_i.wdata;
			ram_q <= ram[ram_idx];
		end
	end

	// Region is stable for the whole transfer
	assign bus_i.mem_rdata = (bus_i.region == REG_VRAM) ? vram_q : ram_q;

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			out_latch_o  <= '0;
			shrg_latch_o <= `LASER_SHRG_RESET;
			shrg_en      <= shrg_en_i;  // Switch only counts while in reset
		end
		else
		begin
			if (wr_stb && bus_i.region == REG_IO)
				out_latch_o <= bus_i.wdata;   // Speaker, cassette, VDG mode
			if (wr_stb && bus_i.region == REG_SHRG && shrg_en)
				shrg_latch_o <= bus_i.wdata;
		end
	end

endmodule

/* source/bus_decode.sv */
`timescale 1ns/1ps
`include "laser_cfg.svh"

module bus_decode
	import laser_bus_pkg::*;
(
	input  logic        CLK50MHZ,
	input  logic        RESET_N,
	input  logic        bus_req_i,
	input  addr_t       bus_addr_i,
	input  data_t       bus_wdata_i,
	input  logic        bus_we_i,
	input  logic        bus_iorq_i,
	input  logic        turbo_i,
	output logic        bus_ack_o,
	laser_bus_if.decode bus_o
);

	localparam int CNT_W = $clog2(`LASER_CYC_NORMAL);

	bus_state_t       state;
	logic [CNT_W-1:0] cnt;          // Cycles left before ack
	logic             exec_pend;
	logic             start;

	// Memory map of the base machine, ROM space reads as unmapped
	function automatic region_t classify(input addr_t a, input logic iorq, input logic we);
		region_t r;
		r = REG_NONE;
		if (iorq)
		begin
			if (we && a[7:0] == `LASER_SHRG_PORT)
				r = REG_SHRG;
		end
		else if (a[15:11] == 5'b01101)
			r = REG_IO;
		else if (a[15:11] == 5'b01110)
			r = REG_VRAM;
		else if (a[15:11] == 5'b01111)
			r = REG_RAM;                // 7800-7FFF
		else if (a[15:14] == 2'b10 && a[13:11] != 3'b111)
			r = REG_RAM;                // 8000-B7FF
		return r;
	endfunction

	assign start = (state == BUS_IDLE) && bus_req_i;
	assign bus_ack_o = (state == BUS_ACK);

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			state          <= BUS_IDLE;
			cnt            <= '0;
			exec_pend      <= 1'b0;
			bus_o.exec_stb <= 1'b0;
			bus_o.region   <= REG_NONE;
		end
		else
		begin
			bus_o.exec_stb <= exec_pend;  // One cycle after the req sample
			exec_pend      <= 1'b0;
			case (state)
				BUS_IDLE:
					if (bus_req_i)
					begin
						state        <= BUS_RUN;
						exec_pend    <= 1'b1;
						bus_o.region <= classify(bus_addr_i, bus_iorq_i, bus_we_i);
						if (turbo_i)
							cnt <= CNT_W'(`LASER_CYC_TURBO - 1);
						else
							cnt <= CNT_W'(`LASER_CYC_NORMAL - 1);
					end
				BUS_RUN:
					if (cnt == '0)
						state <= BUS_ACK;
					else
						cnt <= cnt - 1'b1;
				BUS_ACK:
					if (!bus_req_i)
						state <= BUS_IDLE;  // Master finished the handshake
				default:
					state <= BUS_IDLE;
			endcase
		end
	end

	// Transfer fields, held until the next request
	always_ff @(posedge CLK50MHZ)
	begin
		if (start)
		begin
			bus_o.addr  <= bus_addr_i;
			bus_o.wdata <= bus_wdata_i;
			bus_o.we    <= bus_we_i;
		end
	end

endmodule

/* source/laser_bus_if.sv */
`timescale 1ns/1ps

interface laser_bus_if
	import laser_bus_pkg::*;
();

	region_t  region;
	addr_t    addr;
	data_t    wdata;
	logic     we;
	logic     exec_stb;     // First cycle of the transfer, one clock wide
	data_t    mem_rdata;

	modport decode
	(
		output region, addr, wdata, we, exec_stb
	);

	modport execute
	(
		input  region, addr, wdata, we, exec_stb,
		output mem_rdata
	);

	modport result
	(
		input  region, addr, mem_rdata
	);

endinterface

/* source/laser_kbd_pkg.sv */
package laser_kbd_pkg;

	typedef logic [7:0] ps2_code_t;

	// Active low, bit index is row * 8 + column
	typedef logic [63:0] key_matrix_t;

	// One bit per strobe address line A0..A7
	typedef logic [7:0] key_row_t;

endpackage

/* source/laser_bus_pkg.sv */
`include "laser_cfg.svh"

package laser_bus_pkg;

	typedef logic [`LASER_ADDR_W-1:0]  addr_t;
	typedef logic [`LASER_DATA_W-1:0]  data_t;
	typedef logic [`LASER_VRAM_AW-1:0] vram_addr_t;
	typedef logic [`LASER_RAM_AW-1:0]  ram_addr_t;

	// Target of one bus transfer
	typedef enum logic [2:0]
	{
		REG_NONE,
		REG_IO,       // 6800-6FFF keyboard and output latch
		REG_VRAM,     // 7000-77FF
		REG_RAM,      // 7800-B7FF
		REG_SHRG      // I/O write to the graphics port
	} region_t;

	// Handshake sequencer
	typedef enum logic [1:0]
	{
		BUS_IDLE,
		BUS_RUN,
		BUS_ACK
	} bus_state_t;

endpackage

/* source/laser_cfg.svh */
`ifndef LASER_CFG_SVH
`define LASER_CFG_SVH

// Bus widths
`define LASER_ADDR_W      16
`define LASER_DATA_W      8

// Memory index widths
`define LASER_VRAM_AW     11      // 2 KB video RAM
`define LASER_RAM_AW      14      // 16 KB main RAM

// Transfer length in system clocks, req sample to ack
`define LASER_CYC_NORMAL  14
`define LASER_CYC_TURBO   4

// Extended graphics port
`define LASER_SHRG_PORT   8'h20
`define LASER_SHRG_RESET  8'h08   // GM = 010

`endif
